// File: rtl/riscv_pkg.sv
package riscv_pkg;

	localparam int XLEN = 64;
	localparam int ALEN = 64;
	localparam int ILEN = 32;

	localparam logic [ALEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

	// major opcodes of the supported subset
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_JAL = 7'b1101111;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [6:0] F7_SUB = 7'b0100000;

	localparam logic [1:0] ST_IDLE   = 2'd0; // sequencer states in riscv
	localparam logic [1:0] ST_FETCH  = 2'd1;
	localparam logic [1:0] ST_EXEC   = 2'd2;
	localparam logic [1:0] ST_COMMIT = 2'd3;

	localparam logic [1:0] FS_IDLE = 2'd0; // bus master states in fetch_unit
	localparam logic [1:0] FS_REQ  = 2'd1;
	localparam logic [1:0] FS_ACK  = 2'd2;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_t;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [19:0] imm; // inst[31:12], carved up per format in the decoder
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} inst_u;

endpackage

// File: rtl/alu.sv
`timescale 1ns/100ps

module alu (
	input  logic [riscv_pkg::XLEN-1:0]  a,
	input  logic [riscv_pkg::XLEN-1:0]  b,
	input  logic [riscv_pkg::XLEN-1:0]  imm,
	input  logic                        use_imm,
	input  riscv_pkg::alu_op_t          alu_op,
	output logic [riscv_pkg::XLEN-1:0]  result
);
	import riscv_pkg::*;

	logic [XLEN-1:0] op_b;
	logic            lt;

	assign op_b = use_imm ? imm : b;
	assign lt = $signed(a) < $signed(op_b); // SLT and SLTI compare signed

	always_comb begin
		case (alu_op)
			ALU_ADD:    result = a + op_b;
			ALU_SUB:    result = a - op_b;
			ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt};
			ALU_XOR:    result = a ^ op_b;
			ALU_OR:     result = a | op_b;
			ALU_AND:    result = a & op_b;
			ALU_PASS_B: result = op_b; // LUI hands its shifted immediate straight through
			default:    result = '0;
		endcase
	end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/100ps

module regfile (
	input  logic                        reset,
	input  logic                        rst,
	input  logic [4:0]                  raddr1,
	input  logic [4:0]                  raddr2,
	output logic [riscv_pkg::XLEN-1:0]  rdata1,
	output logic [riscv_pkg::XLEN-1:0]  rdata2,
	input  logic                        we,
	input  logic [4:0]                  waddr,
	input  logic [riscv_pkg::XLEN-1:0]  wdata
);
	import riscv_pkg::*;

	logic [XLEN-1:0] regs [31:1]; // x0 has no storage

	always_ff @(posedge reset or posedge rst) begin
		if (rst) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

	// the sequencer already drops x0 writes, so none should reach the array
	a_no_x0_write: assert property (@(posedge reset) disable iff (rst)
		we |-> (waddr != 5'd0))
		else $error("write enable raised for x0");

endmodule

// File: rtl/decoder.sv
`timescale 1ns/100ps

module decoder (
	input  riscv_pkg::inst_u            inst,
	output logic [4:0]                  rs1,
	output logic [4:0]                  rs2,
	output logic [4:0]                  rd,
	output logic [riscv_pkg::XLEN-1:0]  imm,
	output riscv_pkg::alu_op_t          alu_op,
	output logic                        use_imm,
	output logic                        wen,
	output logic                        is_jal
);
	import riscv_pkg::*;

	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	alu_op_t         f3_op;
	logic            f3_ok;
	logic            f7_ok;

	assign rs1 = inst.r.rs1;
	assign rs2 = inst.r.rs2;
	assign rd  = inst.r.rd;

	assign imm_i = {{(XLEN-12){inst.i.imm[19]}}, inst.i.imm[19:8]};
	assign imm_u = {{(XLEN-32){inst.i.imm[19]}}, inst.i.imm, 12'b0};
	assign imm_j = {{(XLEN-21){inst.i.imm[19]}}, inst.i.imm[19], inst.i.imm[7:0],
		inst.i.imm[8], inst.i.imm[18:9], 1'b0}; // J offset bits are scrambled in the word

	// funct7 of zero, or the SUB encoding on the add slot
	assign f7_ok = (inst.r.funct7 == 7'd0) ||
		(inst.r.funct7 == F7_SUB && inst.r.funct3 == F3_ADD);

	always_comb begin
		f3_ok = 1'b1;
		case (inst.r.funct3)
			F3_ADD: f3_op = ALU_ADD;
			F3_SLT: f3_op = ALU_SLT;
			F3_XOR: f3_op = ALU_XOR;
			F3_OR:  f3_op = ALU_OR;
			F3_AND: f3_op = ALU_AND;
			default: begin
				f3_op = ALU_ADD;
				f3_ok = 1'b0; // shifts and unsigned compares retire as no-ops
			end
		endcase
	end

	always_comb begin
		imm     = imm_i;
		alu_op  = f3_op;
		use_imm = 1'b0;
		wen     = 1'b0;
		is_jal  = 1'b0;
		case (inst.r.opcode)
			OP_IMM: begin
				use_imm = 1'b1;
				wen     = f3_ok;
			end
			OP_REG: begin
				wen = f3_ok && f7_ok;
				if (inst.r.funct7 == F7_SUB) alu_op = ALU_SUB;
			end
			OP_LUI: begin
				imm     = imm_u;
				alu_op  = ALU_PASS_B;
				use_imm = 1'b1;
				wen     = 1'b1;
			end
			OP_JAL: begin
				imm    = imm_j;
				wen    = 1'b1;
				is_jal = 1'b1;
			end
			default: wen = 1'b0; // unknown opcode just advances pc
		endcase
	end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
	input  logic                        reset,
	input  logic                        rst,
	input  logic                        fetch_start,
	input  logic [riscv_pkg::ALEN-1:0]  fetch_pc,
	output logic                        fetch_done,
	output logic [riscv_pkg::ILEN-1:0]  fetch_inst,
	output logic                        ireq,
	output logic [riscv_pkg::ALEN-1:0]  iaddr,
	input  logic                        iack,
	input  logic [riscv_pkg::ILEN-1:0]  idata
);
	import riscv_pkg::*;

	logic [1:0] state;

	always_ff @(posedge reset or posedge rst) begin
		if (rst) begin
			state      <= FS_IDLE;
			ireq       <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				FS_IDLE: begin
					if (fetch_start) begin
						ireq  <= 1'b1;
						state <= FS_REQ;
					end
				end
				FS_REQ: begin
					if (iack) begin
						ireq  <= 1'b0; // data is captured on this same edge
						state <= FS_ACK;
					end
				end
				FS_ACK: begin
					if (!iack) begin
						fetch_done <= 1'b1; // handshake closed, bus free for the next request
						state      <= FS_IDLE;
					end
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

	always_ff @(posedge reset) begin
		if (state == FS_IDLE && fetch_start) iaddr <= fetch_pc;
		if (state == FS_REQ && iack) fetch_inst <= idata;
	end

	a_iaddr_stable: assert property (@(posedge reset) disable iff (rst)
		$past(ireq || iack) |-> (iaddr == $past(iaddr)))
		else $error("iaddr changed during a bus transaction");

	a_no_early_req: assert property (@(posedge reset) disable iff (rst)
		(!ireq && iack) |=> !ireq)
		else $error("ireq raised before iack was seen low");

endmodule

// File: rtl/riscv.sv
`timescale 1ns/100ps

module riscv (
	input  logic                        reset,
	input  logic                        rst,
	output logic                        ireq,
	output logic [riscv_pkg::ALEN-1:0]  iaddr,
	input  logic                        iack,
	input  logic [riscv_pkg::ILEN-1:0]  idata,
	output logic                        commit_valid,
	output logic [riscv_pkg::ALEN-1:0]  commit_pc,
	output logic [riscv_pkg::ILEN-1:0]  commit_inst,
	output logic                        commit_wen,
	output logic [4:0]                  commit_wdest,
	output logic [riscv_pkg::XLEN-1:0]  commit_wdata
);
	import riscv_pkg::*;

	logic [1:0]      state;
	logic [ALEN-1:0] pc;
	logic [ALEN-1:0] pc_plus4;
	logic [ALEN-1:0] next_pc;
	inst_u           inst_q;
	logic [XLEN-1:0] result_q;

	logic            fetch_start;
	logic [ALEN-1:0] fetch_pc;
	logic            fetch_done;
	logic [ILEN-1:0] fetch_inst;

	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic [XLEN-1:0] imm;
	alu_op_t         alu_op;
	logic            use_imm;
	logic            wen;
	logic            is_jal;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;
	logic [XLEN-1:0] alu_result;

	assign pc_plus4 = pc + 64'd4;
	assign next_pc = is_jal ? pc + imm : pc_plus4;

	// the next fetch goes out in the same cycle as the commit record
	assign fetch_start = (state == ST_IDLE) || (state == ST_COMMIT);
	assign fetch_pc = (state == ST_COMMIT) ? next_pc : pc;

	assign commit_valid = (state == ST_COMMIT);
	assign commit_pc = pc;
	assign commit_inst = inst_q;
	assign commit_wen = commit_valid && wen && (rd != 5'd0);
	assign commit_wdest = rd;
	assign commit_wdata = result_q;

	always_ff @(posedge reset or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
			pc    <= RESET_PC;
		end else begin
			case (state)
				ST_IDLE:  state <= ST_FETCH;
				ST_FETCH: if (fetch_done) state <= ST_EXEC;
				ST_EXEC:  state <= ST_COMMIT;
				default: begin
					state <= ST_FETCH;
					pc    <= next_pc;
				end
			endcase
		end
	end

	always_ff @(posedge reset) begin
		if (fetch_done) inst_q <= fetch_inst;
		if (state == ST_EXEC) result_q <= is_jal ? pc_plus4 : alu_result; // JAL links pc+4
	end

	fetch_unit fetch_unit_inst (
		.reset (reset), .rst (rst),
		.fetch_start (fetch_start), .fetch_pc (fetch_pc),
		.fetch_done (fetch_done), .fetch_inst (fetch_inst),
		.ireq (ireq), .iaddr (iaddr), .iack (iack), .idata (idata)
	);

	decoder decoder_inst (
		.inst (inst_q), .rs1 (rs1), .rs2 (rs2), .rd (rd), .imm (imm),
		.alu_op (alu_op), .use_imm (use_imm), .wen (wen), .is_jal (is_jal)
	);

	regfile regfile_inst (
		.reset (reset), .rst (rst),
		.raddr1 (rs1), .raddr2 (rs2), .rdata1 (rdata1), .rdata2 (rdata2),
		.we (commit_wen), .waddr (commit_wdest), .wdata (commit_wdata)
	);

	alu alu_inst (
		.a (rdata1), .b (rdata2), .imm (imm), .use_imm (use_imm),
		.alu_op (alu_op), .result (alu_result)
	);

	a_exec_then_commit: assert property (@(posedge reset) disable iff (rst)
		fetch_done |=> (state == ST_EXEC) ##1 commit_valid)
		else $error("commit did not follow fetch_done after one execute cycle");

	a_commit_refetch: assert property (@(posedge reset) disable iff (rst)
		commit_valid |=> !commit_valid && ireq)
		else $error("commit was not a single pulse followed by a new request");

endmodule

// File: rtl/core.sv
`timescale 1ns/100ps

module core (
	input  logic                        reset,
	input  logic                        clk,
	output logic                        ireq,
	output logic [riscv_pkg::ALEN-1:0]  iaddr,
	input  logic                        iack,
	input  logic [riscv_pkg::ILEN-1:0]  idata,
	output logic                        commit_valid,
	output logic [riscv_pkg::ALEN-1:0]  commit_pc,
	output logic [riscv_pkg::ILEN-1:0]  commit_inst,
	output logic                        commit_wen,
	output logic [4:0]                  commit_wdest,
	output logic [riscv_pkg::XLEN-1:0]  commit_wdata
);

	logic armed;
	logic core_rst;

	// core_rst holds through the external reset and one more cycle after release
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			armed    <= 1'b0;
			core_rst <= 1'b1;
		end else if (!armed) begin
			armed <= 1'b1; // first edge after release, core_rst still high
		end else begin
			core_rst <= 1'b0;
		end
	end

	riscv riscv_inst (
		.reset        (reset),
		.rst          (core_rst),
		.ireq         (ireq),
		.iaddr        (iaddr),
		.iack         (iack),
		.idata        (idata),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_inst  (commit_inst),
		.commit_wen   (commit_wen),
		.commit_wdest (commit_wdest),
		.commit_wdata (commit_wdata)
	);

endmodule

// File: tb/imem_model.sv
`timescale 1ns/100ps

module imem_model (
	input  logic                        reset,
	input  logic                        clk,
	input  logic                        ireq,
	input  logic [riscv_pkg::ALEN-1:0]  iaddr,
	output logic                        iack,
	output logic [riscv_pkg::ILEN-1:0]  idata
);
	import riscv_pkg::*;

	logic [ILEN-1:0] mem [64]; // filled by the testbench before reset is released
	integer          seed;
	int              wait_cycles;
	logic            counting;
	logic [ALEN-1:0] offset;

	initial begin
		seed = 94;
		iack = 1'b0;
		idata = '0;
		counting = 1'b0;
		wait_cycles = 0;
		forever begin
			@(posedge reset);
			#10;
			if (clk) begin
				iack = 1'b0;
				counting = 1'b0;
			end else if (ireq && !iack) begin
				if (!counting) begin
					wait_cycles = {$random(seed)} % 4; // 0 to 3 cycles before the ack
					counting = 1'b1;
				end
				if (wait_cycles == 0) begin
					offset = iaddr - RESET_PC;
					idata = mem[offset[7:2]];
					iack = 1'b1;
					counting = 1'b0;
				end else begin
					wait_cycles = wait_cycles - 1;
				end
			end else if (iack && !ireq) begin
				if (!counting) begin
					wait_cycles = {$random(seed)} % 4; // ack may linger 0 to 3 cycles
					counting = 1'b1;
				end
				if (wait_cycles == 0) begin
					iack = 1'b0; // request dropped, close the handshake
					counting = 1'b0;
				end else begin
					wait_cycles = wait_cycles - 1;
				end
			end
		end
	end

endmodule

// File: tb/tb_core.sv
`timescale 1ns/100ps

module tb_core;
	import riscv_pkg::*;

	localparam int NUM_INSTS = 40;
	localparam int CYCLES_PER_INST = 20;
	localparam int TIMEOUT_CYCLES = NUM_INSTS * CYCLES_PER_INST;
	localparam int NUM_TESTS = 6;

	logic            reset; // clock
	logic            clk; // asynchronous reset
	logic            ireq;
	logic [ALEN-1:0] iaddr;
	logic            iack;
	logic [ILEN-1:0] idata;
	logic            commit_valid;
	logic [ALEN-1:0] commit_pc;
	logic [ILEN-1:0] commit_inst;
	logic            commit_wen;
	logic [4:0]      commit_wdest;
	logic [XLEN-1:0] commit_wdata;

	logic [ILEN-1:0] prog [64];
	logic [XLEN-1:0] gold [32];
	logic [ALEN-1:0] exp_pc;
	logic [ALEN-1:0] exp_next_pc;
	logic [ALEN-1:0] pc_off;
	logic [5:0]      exp_idx;
	logic            exp_wen;
	logic [4:0]      exp_rd;
	logic [XLEN-1:0] exp_wdata;
	int              errors;
	int              cycles;
	int              rel_cnt;
	int              cur_test;
	int              total_checks;
	int              test_checks [NUM_TESTS];
	int              test_errors [NUM_TESTS];
	string           test_name [NUM_TESTS];
	logic            was_commit;
	logic            was_req;
	logic            prev_req;
	logic            finished;
	logic [ALEN-1:0] was_off;

	core dut (
		.reset (reset), .clk (clk), .ireq (ireq), .iaddr (iaddr), .iack (iack), .idata (idata),
		.commit_valid (commit_valid), .commit_pc (commit_pc), .commit_inst (commit_inst),
		.commit_wen (commit_wen), .commit_wdest (commit_wdest), .commit_wdata (commit_wdata)
	);

	imem_model imem (
		.reset (reset), .clk (clk), .ireq (ireq), .iaddr (iaddr), .iack (iack), .idata (idata)
	);

	function automatic logic [31:0] itype_word(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, OP_IMM};
	endfunction

	function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	function automatic logic funct3_known(input logic [2:0] f3);
		return f3 == F3_ADD || f3 == F3_SLT || f3 == F3_XOR || f3 == F3_OR || f3 == F3_AND;
	endfunction

	function automatic logic [XLEN-1:0] arith_result(input logic [2:0] f3, input logic sub,
			input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
		logic [XLEN-1:0] r;
		case (f3)
			F3_ADD:  r = sub ? x - y : x + y;
			F3_SLT:  r = ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
			F3_XOR:  r = x ^ y;
			F3_OR:   r = x | y;
			F3_AND:  r = x & y;
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic logic [5:0] last_index(input int test);
		case (test)
			1:       return 6'd9;
			2:       return 6'd24;
			3:       return 6'd32;
			default: return 6'd39;
		endcase
	endfunction

	task automatic value_error(input int test, input string msg);
		$display("error at %0t: %s", $time, msg);
		errors++;
		test_errors[test]++;
	endtask

	task automatic protocol_error(input int test, input string msg);
		$display("%s, seen at time %0t", msg, $time);
		errors++;
		test_errors[test]++;
	endtask

	task automatic finish_test();
		$display("test %-12s %0d checked, %0d errors", test_name[cur_test],
			test_checks[cur_test], test_errors[cur_test]);
		cur_test++;
	endtask

	task automatic load_program();
		prog[0] = itype_word(F3_ADD, 5'd1, 5'd0, 12'd5);
		prog[1] = itype_word(F3_ADD, 5'd2, 5'd0, 12'hffd);
		prog[2] = itype_word(F3_ADD, 5'd3, 5'd1, 12'h7ff);
		prog[3] = itype_word(F3_SLT, 5'd4, 5'd1, 12'd1);
		prog[4] = itype_word(F3_SLT, 5'd5, 5'd2, 12'hfff);
		prog[5] = itype_word(F3_XOR, 5'd6, 5'd2, 12'h555);
		prog[6] = itype_word(F3_OR, 5'd7, 5'd1, 12'hf00);
		prog[7] = itype_word(F3_AND, 5'd8, 5'd3, 12'h0f0);
		prog[8] = itype_word(F3_ADD, 5'd0, 5'd1, 12'd7); // x0 destination
		prog[9] = itype_word(F3_ADD, 5'd9, 5'd0, 12'h800);
		prog[10] = rtype_word(7'd0, F3_ADD, 5'd10, 5'd1, 5'd2);
		prog[11] = rtype_word(F7_SUB, F3_ADD, 5'd11, 5'd1, 5'd2);
		prog[12] = rtype_word(F7_SUB, F3_ADD, 5'd12, 5'd2, 5'd3);
		prog[13] = rtype_word(7'd0, F3_SLT, 5'd13, 5'd2, 5'd1);
		prog[14] = rtype_word(7'd0, F3_SLT, 5'd14, 5'd1, 5'd2);
		prog[15] = rtype_word(7'd0, F3_XOR, 5'd15, 5'd6, 5'd7);
		prog[16] = rtype_word(7'd0, F3_OR, 5'd16, 5'd4, 5'd9);
		prog[17] = rtype_word(7'd0, F3_AND, 5'd17, 5'd7, 5'd2);
		prog[18] = rtype_word(7'd0, F3_ADD, 5'd0, 5'd1, 5'd3);
		prog[19] = rtype_word(7'd0, F3_ADD, 5'd18, 5'd0, 5'd0); // x0 must still read zero
		prog[20] = rtype_word(F7_SUB, F3_ADD, 5'd19, 5'd0, 5'd1);
		prog[21] = rtype_word(7'd0, F3_SLT, 5'd20, 5'd19, 5'd0);
		prog[22] = rtype_word(7'd0, F3_ADD, 5'd21, 5'd21, 5'd19);
		prog[23] = rtype_word(7'd0, F3_XOR, 5'd22, 5'd19, 5'd19);
		prog[24] = rtype_word(7'd0, F3_OR, 5'd23, 5'd0, 5'd10);
		prog[25] = lui_word(5'd24, 20'h12345);
		prog[26] = lui_word(5'd25, 20'h80000);
		prog[27] = rtype_word(7'd0, F3_ADD, 5'd26, 5'd24, 5'd25);
		prog[28] = jal_word(5'd27, 21'd12); // skips the next two words
		prog[29] = itype_word(F3_ADD, 5'd28, 5'd0, 12'd1);
		prog[30] = itype_word(F3_ADD, 5'd29, 5'd0, 12'd1);
		prog[31] = itype_word(F3_ADD, 5'd30, 5'd27, 12'd0);
		prog[32] = lui_word(5'd0, 20'habcde);
		prog[33] = {12'h123, 5'd1, 3'b000, 5'd5, 7'b0001011}; // custom-0 opcode aimed at x5
		prog[34] = itype_word(F3_ADD, 5'd31, 5'd5, 12'd1);
		prog[35] = rtype_word(7'd0, F3_OR, 5'd1, 5'd0, 5'd5);
		prog[36] = rtype_word(7'd0, F3_ADD, 5'd2, 5'd1, 5'd30);
		prog[37] = rtype_word(F7_SUB, F3_ADD, 5'd3, 5'd2, 5'd26);
		prog[38] = rtype_word(7'd0, F3_SLT, 5'd4, 5'd26, 5'd0);
		prog[39] = itype_word(F3_ADD, 5'd5, 5'd4, 12'h7ff);
		for (int k = NUM_INSTS; k < 64; k++) begin
			prog[k] = itype_word(F3_ADD, 5'd0, 5'd0, {6'd0, 6'(k)});
		end
	endtask

	assign pc_off = exp_pc - RESET_PC;
	assign exp_idx = pc_off[7:2];

	// golden decode of the program word at the expected pc, against the model registers
	always_comb begin : golden_decode
		logic [ILEN-1:0] word;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm_j;
		logic            write;
		word = prog[exp_idx];
		a = gold[word[19:15]];
		b = gold[word[24:20]];
		imm_j = {{44{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
		exp_rd = word[11:7];
		exp_next_pc = exp_pc + 64'd4;
		exp_wdata = '0;
		case (word[6:0])
			OP_IMM: begin
				write = funct3_known(word[14:12]);
				exp_wdata = arith_result(word[14:12], 1'b0, a, {{52{word[31]}}, word[31:20]});
			end
			OP_REG: begin
				write = funct3_known(word[14:12]) && (word[31:25] == 7'd0 ||
					(word[31:25] == F7_SUB && word[14:12] == F3_ADD));
				exp_wdata = arith_result(word[14:12], word[31:25] == F7_SUB, a, b);
			end
			OP_LUI: begin
				write = 1'b1;
				exp_wdata = {{32{word[31]}}, word[31:12], 12'd0};
			end
			OP_JAL: begin
				write = 1'b1;
				exp_wdata = exp_pc + 64'd4;
				exp_next_pc = exp_pc + imm_j;
			end
			default: write = 1'b0;
		endcase
		exp_wen = write && exp_rd != 5'd0;
	end

	always @(posedge reset or posedge clk) begin
		if (clk) begin
			exp_pc <= RESET_PC;
			rel_cnt <= 0;
			for (int k = 0; k < 32; k++) begin
				gold[k] <= '0;
			end
		end else begin
			if (rel_cnt < 4) rel_cnt <= rel_cnt + 1; // edges since reset release
			if (commit_valid) begin
				if (exp_wen) gold[exp_rd] <= exp_wdata;
				exp_pc <= exp_next_pc;
			end
		end
	end

	a_reset_quiet: assert property (@(posedge reset) disable iff (clk)
		(rel_cnt <= 2) |-> !ireq && !commit_valid && !commit_wen)
		else protocol_error(0, "the core requested or committed before its reset ended");
	a_first_fetch: assert property (@(posedge reset) disable iff (clk)
		(rel_cnt == 3) |-> ireq && iaddr == RESET_PC)
		else value_error(0, "first fetch late or not at the reset pc");
	a_req_rise: assert property (@(posedge reset) disable iff (clk)
		$rose(ireq) |-> !$past(iack))
		else protocol_error(5, "ireq went high while iack was still high");
	a_req_fall: assert property (@(posedge reset) disable iff (clk)
		$fell(ireq) |-> $past(iack))
		else protocol_error(5, "ireq was dropped before any iack");
	a_addr_stable: assert property (@(posedge reset) disable iff (clk)
		$past(ireq || iack) |-> $stable(iaddr))
		else protocol_error(5, "iaddr moved during a bus transaction");
	a_addr_range: assert property (@(posedge reset) disable iff (clk)
		ireq |-> (iaddr - RESET_PC) < 64'd256 && iaddr[1:0] == 2'b00)
		else protocol_error(5, "fetch address fell outside the program memory");
	a_commit_pc: assert property (@(posedge reset) disable iff (clk)
		commit_valid |-> commit_pc == exp_pc)
		else value_error(cur_test, "commit_pc differs from the expected pc");
	a_commit_inst: assert property (@(posedge reset) disable iff (clk)
		commit_valid |-> commit_inst == prog[exp_idx])
		else value_error(cur_test, "commit_inst differs from the program word");
	a_commit_wen: assert property (@(posedge reset) disable iff (clk)
		commit_valid |-> commit_wen == exp_wen)
		else value_error(cur_test, "commit_wen differs from the golden model");
	a_commit_data: assert property (@(posedge reset) disable iff (clk)
		(commit_valid && exp_wen) |-> commit_wdest == exp_rd && commit_wdata == exp_wdata)
		else value_error(cur_test, "register write differs from the golden model");

	initial begin
		reset = 1'b0;
		forever #50 reset = ~reset;
	end

	always @(posedge reset) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles before the last instruction retired", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		clk = 1'b1;
		errors = 0;
		cycles = 0;
		cur_test = 0;
		total_checks = 0;
		prev_req = 1'b0;
		finished = 1'b0;
		test_name[0] = "reset";
		test_name[1] = "i-type";
		test_name[2] = "r-type";
		test_name[3] = "lui/jal";
		test_name[4] = "unknown-op";
		test_name[5] = "bus";
		for (int k = 0; k < NUM_TESTS; k++) begin
			test_checks[k] = 0;
			test_errors[k] = 0;
		end
		load_program();
		for (int k = 0; k < 64; k++) begin
			imem.mem[k] = prog[k];
		end
		repeat (5) @(posedge reset);
		#10;
		clk = 1'b0;
		while (!finished) begin
			@(posedge reset);
			was_commit = commit_valid;
			was_off = commit_pc - RESET_PC;
			was_req = ireq;
			#10; // past this edge's assertion checks
			if (was_req && !prev_req) test_checks[5]++;
			prev_req = was_req;
			if (cur_test == 0) begin
				test_checks[0]++;
				if (rel_cnt == 4) finish_test();
			end else if (was_commit) begin
				test_checks[cur_test]++;
				if (was_off[7:2] == last_index(cur_test)) finish_test();
				if (cur_test == 5) begin
					finish_test();
					finished = 1'b1;
				end
			end
		end
		for (int k = 0; k < NUM_TESTS; k++) begin
			total_checks += test_checks[k];
		end
		$display("tests %0d, checked %0d, errors %0d", NUM_TESTS, total_checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
rtl/riscv_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/decoder.sv
rtl/fetch_unit.sv
rtl/riscv.sv
rtl/core.sv
tb/imem_model.sv
tb/tb_core.sv
